//--- run_sim.sh
#!/usr/bin/env bash
# Builds vfifo_tb with Verilator and runs it from the project root
set -u

if ! cd "$(dirname "$0")"; then
	echo "Cannot change to the project directory"
	exit 1
fi

if ! verilator --binary --timing --assert --top-module vfifo_tb -f vfifo.f; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vvfifo_tb 2>&1)
sim_status=$?
echo "$sim_output"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qxF '*** PASSED ***' <<< "$sim_output"; then
	exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

//--- src/burst_reader.sv
/* Reads one burst of burst_beats words per start pulse from the ring read pointer.
   The sink must have room for a whole burst; rresp is not checked. */
`timescale 1ns/1ps
`default_nettype none

module burst_reader (
	input logic clk_axi,
	input logic rst_axi_n,

	input logic start,
	output logic busy,

	word_stream_if.producer dst,

	output logic [vfifo_cfg_pkg::addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input logic arready,

	input vfifo_cfg_pkg::word_t rdata,
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,
	output logic rready
);
	import vfifo_cfg_pkg::*;
	import vfifo_types_pkg::*;

	engine_state_e state;
	logic [addr_width-1:0] rd_ptr;
	logic [beat_width-1:0] beat;
	logic last_beat;

	assign busy = state != idle;

	assign araddr = rd_ptr;
	assign arlen = 8'(burst_beats - 1);
	assign arvalid = state == addr;

	assign dst.data = rdata;
	assign dst.valid = (state == data) && rvalid;
	assign dst.level = '0;
	assign rready = (state == data) && dst.ready;

	assign last_beat = beat == beat_width'(burst_beats - 1);

	// The beat count ends the burst, rlast is only cross-checked
	always_ff @(posedge clk_axi) begin
		if (!rst_axi_n) begin
			state <= idle;
			rd_ptr <= addr_width'(region_base);
			beat <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= addr;
					end
				end
				addr: begin
					if (arready) begin
						state <= data;
						beat <= '0;
					end
				end
				data: begin
					if (rvalid && rready) begin
						beat <= beat + 1'b1;
						if (last_beat) begin
							state <= idle;
							rd_ptr <= next_burst_addr(rd_ptr);
						end
					end
				end
				default: state <= idle;
			endcase
		end
	end

	a_rlast_on_final_beat: assert property (@(posedge clk_axi) disable iff (!rst_axi_n)
		rvalid && rready |-> rlast == last_beat);

endmodule

`default_nettype wire

//--- src/burst_writer.sv
/* Writes one burst of burst_beats words per start pulse at the ring write pointer.
   Expects a full burst already waiting in the source; bresp is not checked. */
`timescale 1ns/1ps
`default_nettype none

module burst_writer (
	input logic clk_axi,
	input logic rst_axi_n,

	input logic start,
	output logic busy,

	word_stream_if.consumer src,

	output logic [vfifo_cfg_pkg::addr_width-1:0] awaddr,
	output logic [7:0] awlen,
	output logic awvalid,
	input logic awready,

	output vfifo_cfg_pkg::word_t wdata,
	output logic wlast,
	output logic wvalid,
	input logic wready,

	input logic [1:0] bresp,
	input logic bvalid,
	output logic bready
);
	import vfifo_cfg_pkg::*;
	import vfifo_types_pkg::*;

	engine_state_e state;
	logic [addr_width-1:0] wr_ptr;
	logic [beat_width-1:0] beat;

	assign busy = state != idle;

	assign awaddr = wr_ptr;
	assign awlen = 8'(burst_beats - 1);
	assign awvalid = state == addr;

	// W beats come straight from the source head
	assign wdata = src.data;
	assign wvalid = (state == data) && src.valid;
	assign wlast = beat == beat_width'(burst_beats - 1);
	assign src.ready = (state == data) && wready;

	assign bready = state == resp;

	always_ff @(posedge clk_axi) begin
		if (!rst_axi_n) begin
			state <= idle;
			wr_ptr <= addr_width'(region_base);
			beat <= '0;
		end else begin
			case (state)
				idle: begin
					if (start) begin
						state <= addr;
					end
				end
				addr: begin
					if (awready) begin
						state <= data;
						beat <= '0;
					end
				end
				data: begin
					if (wvalid && wready) begin
						beat <= beat + 1'b1;
						if (wlast) begin
							state <= resp;
						end
					end
				end
				resp: begin
					if (bvalid) begin
						state <= idle;
						wr_ptr <= next_burst_addr(wr_ptr);
					end
				end
				default: state <= idle;
			endcase
		end
	end

	a_start_when_idle: assert property (@(posedge clk_axi) disable iff (!rst_axi_n)
		start |-> !busy);

	// The scheduler only starts a write once a whole burst sits in the ingress buffer
	a_burst_ready: assert property (@(posedge clk_axi) disable iff (!rst_axi_n)
		start |-> src.level >= level_width'(burst_beats));

endmodule

`default_nettype wire

//--- src/stream_buffer.sv
/* Synchronous word FIFO of buf_depth entries; rd.data is valid from the head entry.
   No bypass, so a written word shows on rd one cycle later. */
`timescale 1ns/1ps
`default_nettype none

module stream_buffer (
	input logic clk_axi,
	input logic rst_axi_n,

	input vfifo_cfg_pkg::word_t wr_data,
	input logic wr_valid,
	output logic wr_ready,

	word_stream_if.producer rd,

	output logic [vfifo_cfg_pkg::level_width-1:0] level
);
	import vfifo_cfg_pkg::*;

	word_t mem [buf_depth];
	logic [buf_ptr_width-1:0] wr_ptr;
	logic [buf_ptr_width-1:0] rd_ptr;
	logic [level_width-1:0] count;
	logic push;
	logic pop;

	assign wr_ready = count < level_width'(buf_depth);
	assign push = wr_valid && wr_ready;

	assign rd.valid = count != '0;
	assign rd.data = mem[rd_ptr];
	assign pop = rd.valid && rd.ready;

	assign level = count;
	assign rd.level = count;

	always_ff @(posedge clk_axi) begin
		if (push) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// Pointers wrap on their own since buf_depth is a power of two
	always_ff @(posedge clk_axi) begin
		if (!rst_axi_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + level_width'(push) - level_width'(pop);
		end
	end

	// A write never lands on the unread head entry
	a_no_write_when_full: assert property (@(posedge clk_axi) disable iff (!rst_axi_n)
		push |-> count == '0 || wr_ptr != rd_ptr);

endmodule

`default_nettype wire

//--- src/vfifo_cfg_pkg.sv
/* Sizes of the stream, the buffers and the memory ring.
   buf_depth and burst_beats are powers of two, and the ring holds whole bursts only. */
`default_nettype none

package vfifo_cfg_pkg;

	localparam int word_width = 32;
	localparam int addr_width = 12;
	localparam int burst_beats = 16;
	localparam int beat_width = $clog2(burst_beats);
	localparam int burst_bytes = burst_beats * word_width / 8;

	localparam int region_base = 0;
	localparam int region_words = 256;
	localparam int region_end = region_base + region_words * word_width / 8;
	localparam int max_occupancy = region_words;

	localparam int buf_depth = 2 * burst_beats;
	localparam int buf_ptr_width = $clog2(buf_depth);
	localparam int level_width = $clog2(buf_depth + 1);
	localparam int occ_width = $clog2(max_occupancy + 1);

	typedef logic [word_width-1:0] word_t;

	// Start of the burst after ptr, wrapping at the end of the ring
	function automatic logic [addr_width-1:0] next_burst_addr(input logic [addr_width-1:0] ptr);
		if (ptr == addr_width'(region_end - burst_bytes)) begin
			return addr_width'(region_base);
		end
		return ptr + addr_width'(burst_bytes);
	endfunction

endpackage

`default_nettype wire

//--- src/vfifo_top.sv
/* Virtual FIFO over an AXI memory ring; only whole bursts go to memory.
   Fewer than burst_beats trailing words stay in the ingress buffer until more arrive. */
`timescale 1ns/1ps
`default_nettype none

module vfifo_top (
	input logic clk_axi,
	input logic rst_axi_n,

	input vfifo_cfg_pkg::word_t in_data,
	input logic in_valid,
	output logic in_ready,

	output vfifo_cfg_pkg::word_t out_data,
	output logic out_valid,
	input logic out_ready,

	output logic [vfifo_cfg_pkg::occ_width-1:0] occupancy,

	output logic [vfifo_cfg_pkg::addr_width-1:0] awaddr,
	output logic [7:0] awlen,
	output logic awvalid,
	input logic awready,

	output vfifo_cfg_pkg::word_t wdata,
	output logic wlast,
	output logic wvalid,
	input logic wready,

	input logic [1:0] bresp,
	input logic bvalid,
	output logic bready,

	output logic [vfifo_cfg_pkg::addr_width-1:0] araddr,
	output logic [7:0] arlen,
	output logic arvalid,
	input logic arready,

	input vfifo_cfg_pkg::word_t rdata,
	input logic [1:0] rresp,
	input logic rlast,
	input logic rvalid,
	output logic rready
);
	import vfifo_cfg_pkg::*;
	import vfifo_types_pkg::*;

	sched_state_e state;
	logic write_start;
	logic write_busy;
	logic read_start;
	logic read_busy;
	logic [level_width-1:0] ingress_level;
	logic [level_width-1:0] egress_level;
	logic [occ_width-1:0] occ;

	word_stream_if ingress_stream ();
	word_stream_if egress_stream ();
	word_stream_if out_stream ();

	assign occupancy = occ;

	// Start pulses last one cycle, an engine is done once busy drops after it
	always_ff @(posedge clk_axi) begin
		if (!rst_axi_n) begin
			state <= setup_write;
			write_start <= 1'b0;
			read_start <= 1'b0;
			occ <= '0;
		end else begin
			case (state)
				setup_write: begin
					if (occ < occ_width'(max_occupancy) &&
							ingress_level >= level_width'(burst_beats)) begin
						state <= write_mem;
						write_start <= 1'b1;
					end else begin
						state <= setup_read;
					end
				end
				write_mem: begin
					if (!write_start && !write_busy) begin
						state <= setup_read;
						occ <= occ + occ_width'(burst_beats);
					end
					write_start <= 1'b0;
				end
				setup_read: begin
					// Egress must have room for a whole burst
					if (occ != '0 && egress_level <= level_width'(buf_depth - burst_beats)) begin
						state <= read_mem;
						read_start <= 1'b1;
					end else begin
						state <= setup_write;
					end
				end
				read_mem: begin
					if (!read_start && !read_busy) begin
						state <= setup_write;
						occ <= occ - occ_width'(burst_beats);
					end
					read_start <= 1'b0;
				end
				default: state <= setup_write;
			endcase
		end
	end

	stream_buffer ingress_buffer (
		.clk_axi(clk_axi),
		.rst_axi_n(rst_axi_n),
		.wr_data(in_data),
		.wr_valid(in_valid),
		.wr_ready(in_ready),
		.rd(ingress_stream.producer),
		.level(ingress_level)
	);

	burst_writer burst_writer_inst (
		.clk_axi(clk_axi),
		.rst_axi_n(rst_axi_n),
		.start(write_start),
		.busy(write_busy),
		.src(ingress_stream.consumer),
		.awaddr(awaddr),
		.awlen(awlen),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wlast(wlast),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready)
	);

	burst_reader burst_reader_inst (
		.clk_axi(clk_axi),
		.rst_axi_n(rst_axi_n),
		.start(read_start),
		.busy(read_busy),
		.dst(egress_stream.producer),
		.araddr(araddr),
		.arlen(arlen),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rvalid(rvalid),
		.rready(rready)
	);

	stream_buffer egress_buffer (
		.clk_axi(clk_axi),
		.rst_axi_n(rst_axi_n),
		.wr_data(egress_stream.data),
		.wr_valid(egress_stream.valid),
		.wr_ready(egress_stream.ready),
		.rd(out_stream.producer),
		.level(egress_level)
	);

	assign out_data = out_stream.data;
	assign out_valid = out_stream.valid;
	assign out_stream.ready = out_ready;

endmodule

`default_nettype wire

//--- src/vfifo_types_pkg.sv
/* State encodings for the scheduler and the two burst engines. */
`default_nettype none

package vfifo_types_pkg;

	typedef enum logic [1:0] {
		setup_write,
		write_mem,
		setup_read,
		read_mem
	} sched_state_e;

	// Reader skips resp
	typedef enum logic [1:0] {
		idle,
		addr,
		data,
		resp
	} engine_state_e;

endpackage

`default_nettype wire

//--- src/word_stream_if.sv
/* Ready/valid word stream; level is the fill of the buffer sourcing it, 0 if unknown. */
`timescale 1ns/1ps
`default_nettype none

interface word_stream_if;
	import vfifo_cfg_pkg::*;

	word_t data;
	logic valid;
	logic ready;
	logic [level_width-1:0] level;

	modport producer (
		output data,
		output valid,
		output level,
		input ready
	);

	modport consumer (
		input data,
		input valid,
		input level,
		output ready
	);

endinterface

`default_nettype wire

//--- verif/axi_mem_model.sv
/* AXI slave over a word memory spanning the whole address space; bursts are INCR only.
   awready, wready and arready stall at random, rvalid never does, responses are OKAY. */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
	input logic clk_axi,
	input logic rst_axi_n,

	input logic [vfifo_cfg_pkg::addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,

	input vfifo_cfg_pkg::word_t wdata,
	input logic wlast,
	input logic wvalid,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic [vfifo_cfg_pkg::addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,

	output vfifo_cfg_pkg::word_t rdata,
	output logic [1:0] rresp,
	output logic rlast,
	output logic rvalid,
	input logic rready
);
	import vfifo_cfg_pkg::*;

	localparam int mem_words = 2 ** (addr_width - 2);

	word_t mem [mem_words];
	logic [31:0] rng;
	logic aw_held;
	logic awready_q;
	logic wready_q;
	logic bvalid_q;
	logic arready_q;
	logic rvalid_q;
	logic [addr_width-3:0] w_idx;
	logic [addr_width-3:0] r_idx;
	logic [beat_width-1:0] r_beat;
	logic aw_fire;
	logic w_fire;
	logic ar_fire;
	logic r_fire;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Handshake outputs stay low while in reset
	assign awready = awready_q && rst_axi_n;
	assign wready = wready_q && rst_axi_n;
	assign bvalid = bvalid_q && rst_axi_n;
	assign arready = arready_q && rst_axi_n;
	assign rvalid = rvalid_q && rst_axi_n;
	assign bresp = 2'b00;
	assign rresp = 2'b00;
	assign rdata = mem[r_idx];
	assign rlast = rvalid && r_beat == beat_width'(burst_beats - 1);

	assign aw_fire = awvalid && awready;
	assign w_fire = wvalid && wready;
	assign ar_fire = arvalid && arready;
	assign r_fire = rvalid && rready;

	always_ff @(posedge clk_axi) begin
		if (!rst_axi_n) begin
			rng <= 32'h363d422f;
			aw_held <= 1'b0;
			awready_q <= 1'b0;
			wready_q <= 1'b0;
			bvalid_q <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q <= 1'b0;
			w_idx <= '0;
			r_idx <= '0;
			r_beat <= '0;
		end else begin
			rng <= lcg_next(rng);
			if (aw_fire) begin
				aw_held <= 1'b1;
				w_idx <= awaddr[addr_width-1:2];
			end
			if (w_fire) begin
				mem[w_idx] <= wdata;
				w_idx <= w_idx + 1'b1;
				if (wlast) begin
					aw_held <= 1'b0;
					bvalid_q <= 1'b1;
				end
			end
			if (bvalid && bready) begin
				bvalid_q <= 1'b0;
			end
			// One write burst at a time, next address only after B
			awready_q <= !aw_held && !aw_fire && !bvalid_q && rng[31];
			wready_q <= (aw_held || aw_fire) && !(w_fire && wlast) && rng[29];

			if (ar_fire) begin
				r_idx <= araddr[addr_width-1:2];
				r_beat <= '0;
				rvalid_q <= 1'b1;
			end
			if (r_fire) begin
				r_idx <= r_idx + 1'b1;
				r_beat <= r_beat + 1'b1;
				if (rlast) begin
					rvalid_q <= 1'b0;
				end
			end
			arready_q <= !rvalid_q && !ar_fire && rng[27];
		end
	end

endmodule

`default_nettype wire

//--- verif/vfifo_stimulus.txt
# test_id word_count out_ready_stall_percent expected_final_occupancy
# stall 100 holds out_ready low until full; its word_count is the expected capacity
1 64 0 0
2 160 50 0
3 320 100 0

//--- verif/vfifo_tb.sv
/* Runs the tests listed in verif/vfifo_stimulus.txt against vfifo_top and a memory model.
   A stall of 100 holds out_ready low until the FIFO is full, then drains everything. */
`timescale 1ns/1ps
`default_nettype none

module vfifo_tb;
	import vfifo_cfg_pkg::*;

	localparam int cycle_budget = 40;
	localparam int margin_cycles = 2000;
	localparam int quiet_cycles = 200;
	localparam int settle_cycles = 16;
	localparam int ring_bursts = region_words / burst_beats;
	localparam int burst_span = burst_beats * word_width / 8;

	logic clk_axi;
	logic rst_axi_n;
	word_t in_data;
	logic in_valid;
	logic in_ready;
	word_t out_data;
	logic out_valid;
	logic out_ready;
	logic [occ_width-1:0] occupancy;
	logic [addr_width-1:0] awaddr;
	logic [7:0] awlen;
	logic awvalid;
	logic awready;
	word_t wdata;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [addr_width-1:0] araddr;
	logic [7:0] arlen;
	logic arvalid;
	logic arready;
	word_t rdata;
	logic [1:0] rresp;
	logic rlast;
	logic rvalid;
	logic rready;

	logic [31:0] rng;
	word_t ref_queue [$];
	int test_ids [$];
	int word_counts [$];
	int stall_pcts [$];
	int final_occs [$];
	int total_words;
	int watchdog_cycles;
	int aw_count;
	int ar_count;
	int w_beat;

	vfifo_top vfifo_top_inst (.*);

	axi_mem_model axi_mem_model_inst (.*);

	initial begin
		clk_axi = 1'b0;
		forever #10 clk_axi = ~clk_axi;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_failure(input string reason);
		$display("%s", reason);
		$display("*** FAILED ***");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	task automatic load_stimulus();
		int fd;
		int id;
		int count;
		int stall;
		int occ;
		string line;
		fd = $fopen("verif/vfifo_stimulus.txt", "r");
		if (fd == 0) begin
			report_failure("Could not open verif/vfifo_stimulus.txt for reading");
		end
		total_words = 0;
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.getc(0) != "#" &&
					$sscanf(line, "%d %d %d %d", id, count, stall, occ) == 4) begin
				test_ids.push_back(id);
				word_counts.push_back(count);
				stall_pcts.push_back(stall);
				final_occs.push_back(occ);
				total_words += count;
			end
		end
		$fclose(fd);
		if (test_ids.size() == 0) begin
			report_failure("The stimulus file holds no test lines");
		end
	endtask

	// Called on a falling edge where out_valid and out_ready are both high
	task automatic take_output();
		word_t expected;
		if (ref_queue.size() == 0) begin
			report_failure("An output word arrived with no input word left to match it");
		end
		expected = ref_queue.pop_front();
		check_value(out_data, expected, "output word");
	endtask

	task automatic run_stream_test(input int count, input int stall);
		int sent = 0;
		int received = 0;
		word_t next_word;
		rng = lcg_next(rng);
		next_word = rng;
		while (received < count) begin
			@(negedge clk_axi);
			in_valid = sent < count;
			in_data = next_word;
			if (in_valid && in_ready) begin
				ref_queue.push_back(next_word);
				sent++;
				rng = lcg_next(rng);
				next_word = rng;
			end
			rng = lcg_next(rng);
			out_ready = (rng >> 8) % 100 >= stall;
			if (out_valid && out_ready) begin
				take_output();
				received++;
			end
		end
	endtask

	task automatic run_capacity_test(input int capacity);
		int accepted = 0;
		int quiet = 0;
		int received = 0;
		word_t next_word;
		check_value(32'(capacity), 32'(region_words + 2 * buf_depth), "capacity in stimulus");
		rng = lcg_next(rng);
		next_word = rng;
		// Fill until in_ready has stayed low long enough for any burst to finish
		while (quiet < quiet_cycles) begin
			@(negedge clk_axi);
			out_ready = 1'b0;
			in_valid = 1'b1;
			in_data = next_word;
			if (in_ready) begin
				ref_queue.push_back(next_word);
				accepted++;
				quiet = 0;
				rng = lcg_next(rng);
				next_word = rng;
			end else begin
				quiet++;
			end
		end
		@(negedge clk_axi);
		in_valid = 1'b0;
		check_value(32'(accepted), 32'(capacity), "words accepted before in_ready stayed low");
		check_value(32'(occupancy), 32'(max_occupancy), "occupancy when full");
		while (received < accepted) begin
			@(negedge clk_axi);
			out_ready = 1'b1;
			if (out_valid) begin
				take_output();
				received++;
			end
		end
	endtask

	task automatic wait_for_occupancy(input int expected);
		int cycles = 0;
		while (int'(occupancy) != expected && cycles < settle_cycles) begin
			@(negedge clk_axi);
			cycles++;
		end
		check_value(32'(occupancy), 32'(expected), "occupancy after drain");
	endtask

	// AXI address and burst shape, occupancy granularity
	always @(negedge clk_axi) begin
		if (rst_axi_n) begin
			check_value(32'(occupancy % burst_beats), 32'd0, "occupancy modulo burst_beats");
			if (awvalid && awready) begin
				check_value(32'(awaddr), 32'(region_base + (aw_count % ring_bursts) * burst_span),
					"awaddr");
				check_value(32'(awlen), 32'(burst_beats - 1), "awlen");
				aw_count++;
			end
			if (wvalid && wready) begin
				check_value(32'(wlast), 32'(w_beat == burst_beats - 1), "wlast");
				w_beat = (w_beat + 1) % burst_beats;
			end
			if (arvalid && arready) begin
				check_value(32'(araddr), 32'(region_base + (ar_count % ring_bursts) * burst_span),
					"araddr");
				check_value(32'(arlen), 32'(burst_beats - 1), "arlen");
				ar_count++;
			end
		end
	end

	initial begin
		rst_axi_n = 1'b0;
		in_data = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		rng = 32'h363d422f;
		aw_count = 0;
		ar_count = 0;
		w_beat = 0;
		load_stimulus();
		watchdog_cycles = total_words * cycle_budget + margin_cycles;
		fork
			begin
				repeat (watchdog_cycles) @(posedge clk_axi);
				report_failure($sformatf("Timeout: the tests did not finish within %0d cycles",
					watchdog_cycles));
			end
		join_none
		repeat (5) @(posedge clk_axi);
		@(negedge clk_axi);
		rst_axi_n = 1'b1;
		for (int i = 0; i < test_ids.size(); i++) begin
			$display("Test %0d: %0d words, out_ready stall %0d percent",
				test_ids[i], word_counts[i], stall_pcts[i]);
			if (stall_pcts[i] >= 100) begin
				run_capacity_test(word_counts[i]);
			end else begin
				run_stream_test(word_counts[i], stall_pcts[i]);
			end
			wait_for_occupancy(final_occs[i]);
			// Nothing extra may come out once every word has been matched
			@(negedge clk_axi);
			check_value(32'(out_valid), 32'd0, "out_valid after drain");
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- vfifo.f
src/vfifo_cfg_pkg.sv
src/vfifo_types_pkg.sv
src/word_stream_if.sv
src/stream_buffer.sv
src/burst_writer.sv
src/burst_reader.sv
src/vfifo_top.sv
verif/axi_mem_model.sv
verif/vfifo_tb.sv
